//--- design/vl_regs_pkg.sv
`default_nettype none

// layer register map, byte wide, one block per layer
package vl_regs_pkg;

    // offset width within one layer
    localparam int REG_ADDR_W = 4;

    // register offsets
    localparam logic [REG_ADDR_W-1:0] REG_CTRL    = 4'd0;
    localparam logic [REG_ADDR_W-1:0] REG_MAP_LO  = 4'd1;
    localparam logic [REG_ADDR_W-1:0] REG_MAP_HI  = 4'd2;
    localparam logic [REG_ADDR_W-1:0] REG_TILE_LO = 4'd3;
    localparam logic [REG_ADDR_W-1:0] REG_TILE_HI = 4'd4;
    localparam logic [REG_ADDR_W-1:0] REG_SCRX_LO = 4'd5;
    localparam logic [REG_ADDR_W-1:0] REG_SCRX_HI = 4'd6;
    localparam logic [REG_ADDR_W-1:0] REG_SCRY_LO = 4'd7;
    localparam logic [REG_ADDR_W-1:0] REG_SCRY_HI = 4'd8;

    // ctrl fields
    localparam int CTRL_EN_BIT   = 0;
    localparam int CTRL_MODE_LSB = 5;
    localparam int CTRL_MODE_W   = 3;

    // base address and scroll widths
    localparam int BASE_W   = 16;
    localparam int SCROLL_W = 10;

    // render modes, other codes give a transparent line
    typedef enum logic [CTRL_MODE_W-1:0] {
        MODE_TEXT16  = 3'd0,
        MODE_TEXT256 = 3'd1,
        MODE_BITMAP  = 3'd2
    } vl_mode_e;

endpackage

`default_nettype wire

//--- design/vl_video_pkg.sv
`default_nettype none

// pixel, memory bus and text layout definitions
package vl_video_pkg;

    // colour index, zero is transparent
    typedef logic [7:0] pixel_t;

    // word addressed memory bus
    localparam int BUS_ADDR_W = 18;
    localparam int BUS_DATA_W = 32;

    // text cell geometry
    localparam int GLYPH_H = 8;
    localparam int GLYPH_W = 8;

    // map entry, two per word, low half is the even column
    localparam int MAP_ENTRY_W = 16;
    localparam int ENT_CHAR_LSB = 0;
    // fg is 4 bits in 16-colour text, 8 bits in 256-colour text
    localparam int ENT_FG_LSB = 8;
    // bg only in 16-colour text
    localparam int ENT_BG_LSB = 12;

endpackage

`default_nettype wire

//--- design/vl_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// strobe/ack word bus, one request outstanding
interface vl_bus_if;
    import vl_video_pkg::*;

    logic [BUS_ADDR_W-1:0] addr;
    logic [BUS_DATA_W-1:0] data;
    logic                  strobe;
    logic                  ack;

    // requester side
    modport master (output addr, output strobe, input data, input ack);
    // responder side
    modport slave (input addr, input strobe, output data, output ack);
endinterface

// line buffer write port from a renderer
interface vl_linebuf_if #(
    parameter int IDX_W = 6
);
    import vl_video_pkg::*;

    logic [IDX_W-1:0] wridx;
    pixel_t           wrdata;
    logic             wren;
    // single pulse once the line is fully written
    logic             done;

    modport source (output wridx, output wrdata, output wren, output done);
    modport sink (input wridx, input wrdata, input wren, input done);
endinterface

`default_nettype wire

//--- design/layer_renderer.sv
`timescale 1ns/1ps
`default_nettype none

module layer_renderer #(
    parameter int LINE_WIDTH = 64
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                line_start,
    input  logic [9:0]                          line_y,
    input  logic                                reg_sel,
    input  logic [vl_regs_pkg::REG_ADDR_W-1:0]  reg_addr,
    input  logic [7:0]                          reg_wrdata,
    input  logic                                reg_write,
    output logic [7:0]                          reg_rddata,
    vl_bus_if.master                            bus,
    vl_linebuf_if.source                        linebuf
);
    import vl_regs_pkg::*;
    import vl_video_pkg::*;

    localparam int CW = $clog2(LINE_WIDTH);

    typedef enum logic [2:0] {
        IDLE,
        FETCH_MAP,
        FETCH_GLYPH,
        FETCH_PIX,
        EMIT,
        DONE
    } state_e;

    // host registers
    logic                   reg_enable;
    logic [CTRL_MODE_W-1:0] reg_mode;
    logic [BASE_W-1:0]      reg_map_base;
    logic [BASE_W-1:0]      reg_tile_base;
    logic [SCROLL_W-1:0]    reg_scroll_x;
    logic [SCROLL_W-1:0]    reg_scroll_y;

    // line state
    state_e                 state;
    vl_mode_e               mode_l;
    logic                   blank_l;
    logic [BASE_W-1:0]      map_base_l;
    logic [BASE_W-1:0]      tile_base_l;
    logic [SCROLL_W-1:0]    row;
    logic [CW-1:0]          col;
    logic [CW-1:0]          wr_idx;
    logic [CW-1:0]          sx_mod;
    logic [BUS_DATA_W-1:0]  word;
    logic [7:0]             glyph;
    logic [MAP_ENTRY_W-1:0] entry;
    logic                   fg_bit;
    logic                   mode_ok;
    logic [BUS_ADDR_W-1:0]  fetch_addr;
    pixel_t                 pix;

    // readback, unused bits and offsets are zero
    always_comb begin
        reg_rddata = '0;
        case (reg_addr)
            REG_CTRL: begin
                reg_rddata[CTRL_MODE_LSB +: CTRL_MODE_W] = reg_mode;
                reg_rddata[CTRL_EN_BIT] = reg_enable;
            end
            REG_MAP_LO:  reg_rddata = reg_map_base[7:0];
            REG_MAP_HI:  reg_rddata = reg_map_base[15:8];
            REG_TILE_LO: reg_rddata = reg_tile_base[7:0];
            REG_TILE_HI: reg_rddata = reg_tile_base[15:8];
            REG_SCRX_LO: reg_rddata = reg_scroll_x[7:0];
            REG_SCRX_HI: reg_rddata = 8'(reg_scroll_x[SCROLL_W-1:8]);
            REG_SCRY_LO: reg_rddata = reg_scroll_y[7:0];
            REG_SCRY_HI: reg_rddata = 8'(reg_scroll_y[SCROLL_W-1:8]);
            default:     reg_rddata = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reg_enable    <= 1'b0;
            reg_mode      <= '0;
            reg_map_base  <= '0;
            reg_tile_base <= '0;
            reg_scroll_x  <= '0;
            reg_scroll_y  <= '0;
        end else if (reg_sel && reg_write) begin
            case (reg_addr)
                REG_CTRL: begin
                    reg_mode   <= reg_wrdata[CTRL_MODE_LSB +: CTRL_MODE_W];
                    reg_enable <= reg_wrdata[CTRL_EN_BIT];
                end
                REG_MAP_LO:  reg_map_base[7:0]          <= reg_wrdata;
                REG_MAP_HI:  reg_map_base[15:8]         <= reg_wrdata;
                REG_TILE_LO: reg_tile_base[7:0]         <= reg_wrdata;
                REG_TILE_HI: reg_tile_base[15:8]        <= reg_wrdata;
                REG_SCRX_LO: reg_scroll_x[7:0]          <= reg_wrdata;
                REG_SCRX_HI: reg_scroll_x[SCROLL_W-1:8] <= reg_wrdata[SCROLL_W-9:0];
                REG_SCRY_LO: reg_scroll_y[7:0]          <= reg_wrdata;
                REG_SCRY_HI: reg_scroll_y[SCROLL_W-1:8] <= reg_wrdata[SCROLL_W-9:0];
                default: ;
            endcase
        end
    end

    assign mode_ok = reg_mode inside {MODE_TEXT16, MODE_TEXT256, MODE_BITMAP};
    assign sx_mod  = CW'(reg_scroll_x % LINE_WIDTH);

    // pixel for the current column
    always_comb begin
        // odd cell sits in the high half of the map word
        entry  = col[3] ? word[MAP_ENTRY_W +: MAP_ENTRY_W] : word[0 +: MAP_ENTRY_W];
        // msb of the glyph byte is the leftmost pixel
        fg_bit = glyph[3'(GLYPH_W - 1 - col % GLYPH_W)];
        pix    = '0;
        if (!blank_l) begin
            case (mode_l)
                MODE_BITMAP:  pix = word[8 * col[1:0] +: 8];
                MODE_TEXT16:  pix = fg_bit ? {4'h0, entry[ENT_FG_LSB +: 4]}
                                           : {4'h0, entry[ENT_BG_LSB +: 4]};
                MODE_TEXT256: pix = fg_bit ? entry[ENT_FG_LSB +: 8] : '0;
                default:      pix = '0;
            endcase
        end
    end

    // word address for the pending fetch
    always_comb begin
        case (state)
            FETCH_PIX: fetch_addr = BUS_ADDR_W'(map_base_l)
                + BUS_ADDR_W'(row) * BUS_ADDR_W'(LINE_WIDTH / 4) + BUS_ADDR_W'(col / 4);
            // two words per glyph, four rows each
            FETCH_GLYPH: fetch_addr = BUS_ADDR_W'(tile_base_l)
                + BUS_ADDR_W'({entry[ENT_CHAR_LSB +: 8], 1'b0})
                + BUS_ADDR_W'((row % GLYPH_H) / 4);
            default: fetch_addr = BUS_ADDR_W'(map_base_l)
                + BUS_ADDR_W'(row / GLYPH_H) * BUS_ADDR_W'(LINE_WIDTH / 16)
                + BUS_ADDR_W'(col / 16);
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= IDLE;
            col          <= '0;
            wr_idx       <= '0;
            bus.strobe   <= 1'b0;
            linebuf.wren <= 1'b0;
            linebuf.done <= 1'b0;
        end else begin
            linebuf.wren <= 1'b0;
            linebuf.done <= 1'b0;
            case (state)
                IDLE: begin
                    if (line_start) begin
                        col    <= '0;
                        // column 0 lands at -scroll x
                        wr_idx <= CW'((LINE_WIDTH - int'(sx_mod)) % LINE_WIDTH);
                        if (!reg_enable || !mode_ok) begin
                            state <= EMIT;
                        end else if (reg_mode == MODE_BITMAP) begin
                            state <= FETCH_PIX;
                        end else begin
                            state <= FETCH_MAP;
                        end
                    end
                end
                FETCH_MAP, FETCH_GLYPH, FETCH_PIX: begin
                    // raise after an idle cycle, drop on ack
                    if (!bus.strobe) begin
                        bus.strobe <= 1'b1;
                    end else if (bus.ack) begin
                        bus.strobe <= 1'b0;
                        state <= (state == FETCH_MAP) ? FETCH_GLYPH : EMIT;
                    end
                end
                EMIT: begin
                    linebuf.wren <= 1'b1;
                    col          <= col + 1'b1;
                    wr_idx       <= (wr_idx == CW'(LINE_WIDTH - 1)) ? '0 : wr_idx + 1'b1;
                    if (col == CW'(LINE_WIDTH - 1)) begin
                        state <= DONE;
                    end else if (!blank_l && mode_l == MODE_BITMAP && col[1:0] == 2'd3) begin
                        state <= FETCH_PIX;
                    end else if (!blank_l && mode_l != MODE_BITMAP && col[2:0] == 3'd7) begin
                        // next cell, same word or a new one
                        state <= col[3] ? FETCH_MAP : FETCH_GLYPH;
                    end
                end
                DONE: begin
                    linebuf.done <= 1'b1;
                    state        <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // latched config, fetched data and write payload
    always_ff @(posedge clk) begin
        if (state == IDLE && line_start) begin
            mode_l      <= vl_mode_e'(reg_mode);
            blank_l     <= !reg_enable || !mode_ok;
            map_base_l  <= reg_map_base;
            tile_base_l <= reg_tile_base;
            row         <= line_y + reg_scroll_y;
        end
        // address held stable while strobe is up
        if (!bus.strobe) begin
            bus.addr <= fetch_addr;
        end
        if (bus.strobe && bus.ack) begin
            if (state == FETCH_GLYPH) begin
                glyph <= bus.data[8 * row[1:0] +: 8];
            end else begin
                word <= bus.data;
            end
        end
        linebuf.wridx  <= wr_idx;
        linebuf.wrdata <= pix;
    end

endmodule

`default_nettype wire

//--- design/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter #(
    parameter int NUM_LAYERS = 2
) (
    input  logic    clk,
    input  logic    rst,
    vl_bus_if.slave masters [NUM_LAYERS],
    vl_bus_if.master mem
);
    import vl_video_pkg::*;

    localparam int GW = (NUM_LAYERS > 1) ? $clog2(NUM_LAYERS) : 1;

    logic [GW-1:0]         grant;
    logic [GW-1:0]         next_grant;
    logic [NUM_LAYERS-1:0] req;
    logic [BUS_ADDR_W-1:0] req_addr [NUM_LAYERS];

    for (genvar g = 0; g < NUM_LAYERS; g++) begin : g_port
        assign req[g]      = masters[g].strobe;
        assign req_addr[g] = masters[g].addr;
        // read data broadcast, ack only to the owner
        assign masters[g].data = mem.data;
        assign masters[g].ack  = mem.ack && (grant == GW'(g));
    end

    assign mem.addr   = req_addr[grant];
    assign mem.strobe = req[grant];

    // first requester after the current owner, owner itself last
    always_comb begin
        next_grant = grant;
        for (int k = NUM_LAYERS; k >= 1; k--) begin
            if (req[(int'(grant) + k) % NUM_LAYERS]) begin
                next_grant = GW'((int'(grant) + k) % NUM_LAYERS);
            end
        end
    end

    // move on after an ack, or when the owner is idle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant <= '0;
        end else if (!req[grant] || mem.ack) begin
            grant <= next_grant;
        end
    end

endmodule

`default_nettype wire

//--- design/line_compositor.sv
`timescale 1ns/1ps
`default_nettype none

module line_compositor #(
    parameter int NUM_LAYERS = 2,
    parameter int LINE_WIDTH = 64
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 line_start,
    output logic                 line_busy,
    vl_linebuf_if.sink           linebufs [NUM_LAYERS],
    output logic                 pix_valid,
    output vl_video_pkg::pixel_t pix_data,
    input  logic                 pix_ready
);
    import vl_video_pkg::*;

    localparam int CW = $clog2(LINE_WIDTH);

    logic [NUM_LAYERS-1:0] done_seen;
    logic [NUM_LAYERS-1:0] done_pulse;
    pixel_t                rd_pix [NUM_LAYERS];
    pixel_t                merged;
    logic [CW:0]           rd_cnt;
    logic [CW:0]           out_cnt;
    logic                  rd_valid;
    logic                  advance;
    logic                  issue;

    // whole pipe moves unless the output is held
    assign advance = !pix_valid || pix_ready;
    // read only once every layer has finished its line
    assign issue = advance && line_busy && (&done_seen)
                   && (rd_cnt < (CW + 1)'(LINE_WIDTH));

    for (genvar g = 0; g < NUM_LAYERS; g++) begin : g_layer
        pixel_t line_mem [LINE_WIDTH];

        assign done_pulse[g] = linebufs[g].done;

        always_ff @(posedge clk) begin
            if (linebufs[g].wren) begin
                line_mem[linebufs[g].wridx] <= linebufs[g].wrdata;
            end
            // read address stage
            if (advance) begin
                rd_pix[g] <= line_mem[rd_cnt[CW-1:0]];
            end
        end
    end

    // highest layer with a non-zero pixel wins
    always_comb begin
        merged = '0;
        for (int i = 0; i < NUM_LAYERS; i++) begin
            if (rd_pix[i] != '0) begin
                merged = rd_pix[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            line_busy <= 1'b0;
            done_seen <= '0;
            rd_cnt    <= '0;
            out_cnt   <= '0;
            rd_valid  <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            if (line_start && !line_busy) begin
                line_busy <= 1'b1;
                done_seen <= '0;
                rd_cnt    <= '0;
                out_cnt   <= '0;
            end else begin
                done_seen <= done_seen | done_pulse;
                if (issue) begin
                    rd_cnt <= rd_cnt + 1'b1;
                end
                // line ends with the last accepted pixel
                if (pix_valid && pix_ready) begin
                    out_cnt <= out_cnt + 1'b1;
                    if (out_cnt == (CW + 1)'(LINE_WIDTH - 1)) begin
                        line_busy <= 1'b0;
                    end
                end
            end
            if (advance) begin
                rd_valid  <= issue;
                pix_valid <= rd_valid;
            end
        end
    end

    // registered merge stage
    always_ff @(posedge clk) begin
        if (advance) begin
            pix_data <= merged;
        end
    end

endmodule

`default_nettype wire

//--- design/video_layers_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_layers_top #(
    parameter int NUM_LAYERS = 2,
    parameter int LINE_WIDTH = 64,
    localparam int SEL_W = (NUM_LAYERS > 1) ? $clog2(NUM_LAYERS) : 1
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [SEL_W-1:0]                    reg_layer,
    input  logic [vl_regs_pkg::REG_ADDR_W-1:0]  reg_addr,
    input  logic [7:0]                          reg_wrdata,
    input  logic                                reg_write,
    output logic [7:0]                          reg_rddata,
    input  logic                                line_start,
    input  logic [9:0]                          line_y,
    output logic                                line_busy,
    output logic                                pix_valid,
    output vl_video_pkg::pixel_t                pix_data,
    input  logic                                pix_ready,
    output logic [vl_video_pkg::BUS_ADDR_W-1:0] mem_addr,
    input  logic [vl_video_pkg::BUS_DATA_W-1:0] mem_data,
    output logic                                mem_strobe,
    input  logic                                mem_ack
);
    localparam int CW = $clog2(LINE_WIDTH);

    logic       start;
    logic [7:0] layer_rd [NUM_LAYERS];

    vl_bus_if                   layer_bus [NUM_LAYERS] ();
    vl_bus_if                   mem_bus ();
    vl_linebuf_if #(.IDX_W(CW)) layer_lb [NUM_LAYERS] ();

    // new line only between lines
    assign start = line_start && !line_busy;

    for (genvar g = 0; g < NUM_LAYERS; g++) begin : g_layer
        layer_renderer #(
            .LINE_WIDTH(LINE_WIDTH)
        ) layer_i (
            .clk(clk),
            .rst(rst),
            .line_start(start),
            .line_y(line_y),
            .reg_sel(reg_layer == SEL_W'(g)),
            .reg_addr(reg_addr),
            .reg_wrdata(reg_wrdata),
            .reg_write(reg_write),
            .reg_rddata(layer_rd[g]),
            .bus(layer_bus[g]),
            .linebuf(layer_lb[g])
        );
    end

    // out of range layer reads zero
    assign reg_rddata = (int'(reg_layer) < NUM_LAYERS) ? layer_rd[reg_layer] : 8'h00;

    bus_arbiter #(
        .NUM_LAYERS(NUM_LAYERS)
    ) arb_i (
        .clk(clk),
        .rst(rst),
        .masters(layer_bus),
        .mem(mem_bus)
    );

    // shared memory port
    assign mem_addr     = mem_bus.addr;
    assign mem_strobe   = mem_bus.strobe;
    assign mem_bus.data = mem_data;
    assign mem_bus.ack  = mem_ack;

    line_compositor #(
        .NUM_LAYERS(NUM_LAYERS),
        .LINE_WIDTH(LINE_WIDTH)
    ) comp_i (
        .clk(clk),
        .rst(rst),
        .line_start(line_start),
        .line_busy(line_busy),
        .linebufs(layer_lb),
        .pix_valid(pix_valid),
        .pix_data(pix_data),
        .pix_ready(pix_ready)
    );

endmodule

`default_nettype wire

//--- test/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [vl_video_pkg::BUS_ADDR_W-1:0] addr,
    output logic [vl_video_pkg::BUS_DATA_W-1:0] data,
    input  logic                                strobe,
    output logic                                ack
);
    import vl_video_pkg::*;

    // 4096 words, filled by the testbench
    logic [BUS_DATA_W-1:0] mem [4096];

    integer                seed;
    int                    wait_cnt;
    logic                  rst_q;
    logic                  stb_q;
    logic [BUS_ADDR_W-1:0] addr_q;

    initial begin
        seed     = 32'ha6e9;
        data     = '0;
        ack      = 1'b0;
        wait_cnt = 0;
        forever begin
            @(posedge clk);
            // bus state as seen at the edge
            rst_q  = rst;
            stb_q  = strobe;
            addr_q = addr;
            #1;
            if (rst_q) begin
                ack      = 1'b0;
                wait_cnt = 0;
            end else if (ack) begin
                // single cycle ack, new delay for the next request
                ack      = 1'b0;
                wait_cnt = $random(seed) & 3;
            end else if (stb_q) begin
                if (wait_cnt == 0) begin
                    data = mem[addr_q[11:0]];
                    ack  = 1'b1;
                end else begin
                    wait_cnt = wait_cnt - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tb_video_layers.sv
`timescale 1ns/1ps
`default_nettype none

module tb_video_layers;
    import vl_regs_pkg::*;

    localparam int NL = 2;
    localparam int LINE_WIDTH = 64;

    logic        clk;
    logic        rst;
    logic        reg_layer;
    logic [3:0]  reg_addr;
    logic [7:0]  reg_wrdata;
    logic        reg_write;
    logic [7:0]  reg_rddata;
    logic        line_start;
    logic [9:0]  line_y;
    logic        line_busy;
    logic        pix_valid;
    logic [7:0]  pix_data;
    logic        pix_ready;
    logic [17:0] mem_addr;
    logic [31:0] mem_data;
    logic        mem_strobe;
    logic        mem_ack;

    // register image, and the copy taken at line start
    logic [7:0]  regs [NL][16];
    logic [7:0]  line_regs [NL][16];
    int          cur_y = 0;
    int          accepted = 0;
    int          line_base = 0;
    int          strobe_cycles = 0;
    int          strobe_base = 0;
    logic        rand_ready = 1'b0;
    // output held back on the previous edge
    logic        stall_q = 1'b0;
    logic [7:0]  stall_data = 8'h00;
    integer      seed;

    video_layers_top #(
        .NUM_LAYERS(NL),
        .LINE_WIDTH(LINE_WIDTH)
    ) dut_i (
        .clk(clk),
        .rst(rst),
        .reg_layer(reg_layer),
        .reg_addr(reg_addr),
        .reg_wrdata(reg_wrdata),
        .reg_write(reg_write),
        .reg_rddata(reg_rddata),
        .line_start(line_start),
        .line_y(line_y),
        .line_busy(line_busy),
        .pix_valid(pix_valid),
        .pix_data(pix_data),
        .pix_ready(pix_ready),
        .mem_addr(mem_addr),
        .mem_data(mem_data),
        .mem_strobe(mem_strobe),
        .mem_ack(mem_ack)
    );

    tb_mem_model mem_i (
        .clk(clk),
        .rst(rst),
        .addr(mem_addr),
        .data(mem_data),
        .strobe(mem_strobe),
        .ack(mem_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // output stall, random when enabled
    initial begin
        seed      = 32'ha6e9;
        pix_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            pix_ready = rand_ready ? 1'($random(seed)) : 1'b1;
        end
    end

    task automatic check_value(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("error: time %0t %s got %0h expected %0h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout: %s did not happen in time", what);
        $display("*** FAILED ***");
        $fatal(1, "timeout");
    endtask

    // bits that hold state in each register
    function automatic logic [7:0] reg_mask(input logic [3:0] a);
        case (a)
            REG_CTRL:                   return 8'he1;
            REG_MAP_LO, REG_MAP_HI:     return 8'hff;
            REG_TILE_LO, REG_TILE_HI:   return 8'hff;
            REG_SCRX_LO, REG_SCRY_LO:   return 8'hff;
            REG_SCRX_HI, REG_SCRY_HI:   return 8'h03;
            default:                    return 8'h00;
        endcase
    endfunction

    function automatic logic [31:0] mem_word(input int a);
        return mem_i.mem[12'(a)];
    endfunction

    // one layer's pixel at output x for line y
    function automatic logic [7:0] layer_pixel(input logic l, input int x, input int y);
        int          mode;
        int          map_b;
        int          tile_b;
        int          sx;
        int          sy;
        int          row;
        int          c;
        int          gr;
        logic [31:0] w;
        logic [31:0] g;
        logic [15:0] ent;
        logic [7:0]  gbyte;
        logic        fg;
        mode   = int'(line_regs[l][REG_CTRL][7:5]);
        map_b  = int'({line_regs[l][REG_MAP_HI], line_regs[l][REG_MAP_LO]});
        tile_b = int'({line_regs[l][REG_TILE_HI], line_regs[l][REG_TILE_LO]});
        sx     = int'({line_regs[l][REG_SCRX_HI][1:0], line_regs[l][REG_SCRX_LO]});
        sy     = int'({line_regs[l][REG_SCRY_HI][1:0], line_regs[l][REG_SCRY_LO]});
        row    = (y + sy) % 1024;
        // source column that lands on x
        c      = (x + sx) % LINE_WIDTH;
        if (!line_regs[l][REG_CTRL][0]) begin
            return 8'h00;
        end
        if (mode == int'(MODE_BITMAP)) begin
            w = mem_word(map_b + row * (LINE_WIDTH / 4) + c / 4);
            return 8'(w >> (8 * (c % 4)));
        end
        if (mode != int'(MODE_TEXT16) && mode != int'(MODE_TEXT256)) begin
            return 8'h00;
        end
        // 8x8 cells, two map entries per word
        w     = mem_word(map_b + (row / 8) * (LINE_WIDTH / 16) + c / 16);
        ent   = ((c / 8) % 2 == 1) ? w[31:16] : w[15:0];
        gr    = row % 8;
        g     = mem_word(tile_b + int'(ent[7:0]) * 2 + gr / 4);
        gbyte = 8'(g >> (8 * (gr % 4)));
        fg    = gbyte[3'(7 - c % 8)];
        if (mode == int'(MODE_TEXT16)) begin
            return fg ? {4'h0, ent[11:8]} : {4'h0, ent[15:12]};
        end
        return fg ? ent[15:8] : 8'h00;
    endfunction

    // top non-zero layer wins
    function automatic logic [7:0] expected_pixel(input int x, input int y);
        logic [7:0] result;
        logic [7:0] p;
        result = 8'h00;
        for (int l = 0; l < NL; l++) begin
            p = layer_pixel(1'(l), x, y);
            if (p != 8'h00) begin
                result = p;
            end
        end
        return result;
    endfunction

    // compare every accepted pixel in order
    always @(posedge clk) begin
        if (!rst && stall_q) begin
            // a stalled pixel stays put until taken
            check_value("pix_valid", int'(pix_valid), 1);
            check_value("pix_data", int'(pix_data), int'(stall_data));
        end
        if (!rst && pix_valid && pix_ready) begin
            check_value("line_busy", int'(line_busy), 1);
            check_value("pix_data", int'(pix_data),
                        int'(expected_pixel(accepted - line_base, cur_y)));
            accepted = accepted + 1;
        end
        stall_q    = !rst && pix_valid && !pix_ready;
        stall_data = pix_data;
    end

    always @(posedge clk) begin
        if (mem_strobe) begin
            strobe_cycles = strobe_cycles + 1;
        end
    end

    task automatic write_reg(input logic l, input logic [3:0] a, input logic [7:0] d);
        @(posedge clk);
        #1;
        reg_layer  = l;
        reg_addr   = a;
        reg_wrdata = d;
        reg_write  = 1'b1;
        @(posedge clk);
        #1;
        reg_write  = 1'b0;
        regs[l][a] = d & reg_mask(a);
    endtask

    task automatic read_check(input logic l, input logic [3:0] a);
        @(posedge clk);
        #1;
        reg_layer = l;
        reg_addr  = a;
        @(posedge clk);
        check_value($sformatf("reg_rddata[layer %0d offset %0d]", l, a),
                    int'(reg_rddata), int'(regs[l][a]));
    endtask

    task automatic set_layer(input logic l, input logic [7:0] ctrl, input logic [15:0] map,
                             input logic [15:0] tile, input logic [9:0] sx,
                             input logic [9:0] sy);
        write_reg(l, REG_CTRL, ctrl);
        write_reg(l, REG_MAP_LO, map[7:0]);
        write_reg(l, REG_MAP_HI, map[15:8]);
        write_reg(l, REG_TILE_LO, tile[7:0]);
        write_reg(l, REG_TILE_HI, tile[15:8]);
        write_reg(l, REG_SCRX_LO, sx[7:0]);
        write_reg(l, REG_SCRX_HI, {6'h00, sx[9:8]});
        write_reg(l, REG_SCRY_LO, sy[7:0]);
        write_reg(l, REG_SCRY_HI, {6'h00, sy[9:8]});
    endtask

    task automatic start_line(input int y);
        @(posedge clk);
        #1;
        // layers latch their config here
        line_regs   = regs;
        cur_y       = y;
        line_base   = accepted;
        strobe_base = strobe_cycles;
        line_y      = 10'(y);
        line_start  = 1'b1;
        @(posedge clk);
        #1;
        line_start  = 1'b0;
        check_value("line_busy", int'(line_busy), 1);
    endtask

    task automatic finish_line();
        int n;
        n = 0;
        while (line_busy) begin
            // busy must drop right after the last pixel
            check_value("line_busy after last pixel",
                        int'(accepted - line_base < LINE_WIDTH), 1);
            if (n == 5000) begin
                timeout_fail("line_busy falling at end of line");
            end
            @(posedge clk);
            #1;
            n = n + 1;
        end
        check_value("accepted pixels", accepted - line_base, LINE_WIDTH);
    endtask

    task automatic run_line(input int y);
        start_line(y);
        finish_line();
    endtask

    initial begin
        rst        = 1'b1;
        reg_layer  = 1'b0;
        reg_addr   = '0;
        reg_wrdata = '0;
        reg_write  = 1'b0;
        line_start = 1'b0;
        line_y     = '0;
        for (int l = 0; l < NL; l++) begin
            for (int a = 0; a < 16; a++) begin
                regs[l][a] = 8'h00;
            end
        end
        // scrambled fill, every word differs
        for (int i = 0; i < 4096; i++) begin
            mem_i.mem[12'(i)] = (32'(i) * 32'h9e3779b1) ^ (32'(i) << 20);
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // readback after reset, all ones, then a pattern
        for (int l = 0; l < NL; l++) begin
            for (int a = 0; a < 16; a++) begin
                read_check(1'(l), 4'(a));
            end
            for (int a = 0; a < 16; a++) begin
                write_reg(1'(l), 4'(a), 8'hff);
            end
        end
        for (int l = 0; l < NL; l++) begin
            for (int a = 0; a < 16; a++) begin
                read_check(1'(l), 4'(a));
                write_reg(1'(l), 4'(a), 8'(37 * a + 101 * l));
            end
        end
        for (int l = 0; l < NL; l++) begin
            for (int a = 0; a < 16; a++) begin
                read_check(1'(l), 4'(a));
            end
        end

        // bitmap on layer 0, scroll wraps both ways
        set_layer(1'b0, 8'h41, 16'h0123, 16'h0000, 10'h3f5, 10'h3fe);
        set_layer(1'b1, 8'h00, 16'h0000, 16'h0000, 10'h000, 10'h000);
        run_line(0);
        run_line(1);
        run_line(5);
        run_line(900);

        // 16 colour text under 256 colour text
        set_layer(1'b0, 8'h01, 16'h0800, 16'h0400, 10'h003, 10'h105);
        set_layer(1'b1, 8'h21, 16'h0a00, 16'h0c00, 10'h2c1, 10'h007);
        run_line(0);
        run_line(3);
        run_line(12);
        run_line(1000);

        // no layer active, bus stays quiet
        set_layer(1'b0, 8'h00, 16'h0800, 16'h0400, 10'h003, 10'h105);
        set_layer(1'b1, 8'h20, 16'h0a00, 16'h0c00, 10'h2c1, 10'h007);
        run_line(9);
        check_value("mem_strobe cycles", strobe_cycles - strobe_base, 0);
        // enabled with an unused mode
        write_reg(1'b0, REG_CTRL, 8'he1);
        run_line(10);
        check_value("mem_strobe cycles", strobe_cycles - strobe_base, 0);

        // output stalls on top of random memory delay
        rand_ready = 1'b1;
        set_layer(1'b0, 8'h41, 16'h0200, 16'h0000, 10'h011, 10'h000);
        set_layer(1'b1, 8'h21, 16'h0a00, 16'h0c00, 10'h005, 10'h002);
        run_line(2);
        run_line(77);

        // mid line writes only reach the next line
        start_line(40);
        write_reg(1'b0, REG_SCRX_LO, 8'd33);
        write_reg(1'b1, REG_CTRL, 8'h00);
        write_reg(1'b0, REG_MAP_HI, 8'h05);
        check_value("line_busy", int'(line_busy), 1);
        finish_line();
        run_line(40);
        rand_ready = 1'b0;

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- video_layers.f
design/vl_regs_pkg.sv
design/vl_video_pkg.sv
design/vl_bus_if.sv
design/layer_renderer.sv
design/bus_arbiter.sv
design/line_compositor.sv
design/video_layers_top.sv
test/tb_mem_model.sv
test/tb_video_layers.sv

//--- Makefile
TOP = tb_video_layers

all: run

build:
	verilator --binary --timing -f video_layers.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee /dev/stderr | grep -F -q '*** PASSED ***'

lint:
	verilator --lint-only --timing -f video_layers.f --top-module video_layers_top

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
